/* vec_issue_pkg.sv */
// Shared definitions for the vector issue front end
// Field widths and typedefs of the issue packet
// Issue packet struct stored by the pre-buffer and the FIFO
// Major opcodes and vector memory width codes used by the decoder

package vec_issue_pkg;

  //////////////////////////////
  // Field widths
  //////////////////////////////

  localparam int unsigned InstrWidth   = 32;
  localparam int unsigned HartIdWidth  = 1;
  localparam int unsigned TransIdWidth = 3;

  //////////////////////////////
  // Typedefs
  //////////////////////////////

  typedef logic [InstrWidth-1:0]   instr_t;
  typedef logic [HartIdWidth-1:0]  hartid_t;
  typedef logic [TransIdWidth-1:0] trans_id_t;

  // Instruction fields looked at by the decoder
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] mem_width_t;

  // Issue packet, 36 bits
  typedef struct packed {
    instr_t    instr;
    hartid_t   hartid;
    trans_id_t id;
  } issue_req_t;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Major opcodes
  localparam opcode_t OpcodeOpV     = 7'h57;
  localparam opcode_t OpcodeLoadFp  = 7'h07;
  localparam opcode_t OpcodeStoreFp = 7'h27;

  // Width field codes of vector loads and stores
  localparam mem_width_t VecWidth8  = 3'd0;
  localparam mem_width_t VecWidth16 = 3'd5;
  localparam mem_width_t VecWidth32 = 3'd6;
  localparam mem_width_t VecWidth64 = 3'd7;

endpackage

/* vec_issue_decoder.sv */
// Lightweight issue decoder
// Classifies an instruction word as an accepted vector instruction:
// every OP-V word, and LOAD-FP / STORE-FP with a vector width code

module vec_issue_decoder (
  input  vec_issue_pkg::instr_t instr_i,
  output logic                  accept_o
);

  //////////////////////////////
  // Field extraction
  //////////////////////////////

  vec_issue_pkg::opcode_t    opcode;
  vec_issue_pkg::mem_width_t mem_width;
  logic                      is_vec_width;

  assign opcode    = instr_i[6:0];
  assign mem_width = instr_i[14:12];

  // Width codes 1..3 belong to scalar FP loads and stores
  always_comb begin
    case (mem_width)
      vec_issue_pkg::VecWidth8,
      vec_issue_pkg::VecWidth16,
      vec_issue_pkg::VecWidth32,
      vec_issue_pkg::VecWidth64: is_vec_width = 1'b1;
      default:                   is_vec_width = 1'b0;
    endcase
  end

  //////////////////////////////
  // Accept verdict
  //////////////////////////////

  always_comb begin
    accept_o = 1'b0;

    case (opcode)
      // Arithmetic and vset{i}vl{i} forms alike
      vec_issue_pkg::OpcodeOpV: begin
        accept_o = 1'b1;
      end

      // Vector loads share the major opcode with scalar FP loads
      vec_issue_pkg::OpcodeLoadFp: begin
        accept_o = is_vec_width;
      end

      // Same for stores
      vec_issue_pkg::OpcodeStoreFp: begin
        accept_o = is_vec_width;
      end

      // Everything else stays with the scalar core
      default: begin
        accept_o = 1'b0;
      end
    endcase
  end

endmodule

/* vec_issue_prebuffer.sv */
// One-entry pre-buffer in front of the instruction FIFO
// Holds a taken issue packet and forwards it once the FIFO has room
// Reload on a same-cycle take, cleared by flush-unissued

module vec_issue_prebuffer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      load_i,
  input  vec_issue_pkg::issue_req_t load_data_i,
  input  logic                      fifo_full_i,
  input  logic                      flush_unissued_i,
  output logic                      push_o,
  output vec_issue_pkg::issue_req_t push_data_o
);

  vec_issue_pkg::issue_req_t data_d, data_q;
  logic                      full_d, full_q;

  always_comb begin
    push_o = 1'b0;
    data_d = data_q;
    full_d = full_q;

    // Drain into the FIFO when it has space
    if (full_q && !fifo_full_i) begin
      push_o = 1'b1;
      full_d = 1'b0;
    end

    // New take reloads, even while draining
    if (load_i) begin
      data_d = load_data_i;
      full_d = 1'b1;
    end

    // Flush-unissued wins over push and reload
    if (flush_unissued_i) begin
      push_o = 1'b0;
      full_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q <= '0;
      full_q <= 1'b0;
    end else begin
      data_q <= data_d;
      full_q <= full_d;
    end
  end

  assign push_data_o = data_q;

endmodule

/* vec_instr_fifo.sv */
// Synchronous instruction FIFO for issue packets
// Circular buffer with read/write pointers and a fill counter
// Flush empties it and overrides push and pop of the same cycle
// FifoDepth must be a power of two, at least 2

module vec_instr_fifo #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic                      push_i,
  input  vec_issue_pkg::issue_req_t data_i,
  input  logic                      pop_i,
  output logic                      full_o,
  output logic                      empty_o,
  output vec_issue_pkg::issue_req_t data_o
);

  localparam int unsigned PtrWidth = $clog2(FifoDepth);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [PtrWidth:0]   cnt_t;

  //////////////////////////////
  // Storage and pointers
  //////////////////////////////

  vec_issue_pkg::issue_req_t mem_q [FifoDepth];

  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;

  logic push_en;
  logic pop_en;

  // Pushes arrive gated by the pre-buffer, never while full
  assign push_en = push_i && !flush_i;
  // Pop on empty is a no-op
  assign pop_en  = pop_i && !empty_o && !flush_i;

  assign full_o  = (count_q == cnt_t'(FifoDepth));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  //////////////////////////////
  // Control state
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap on their own since the depth is a power of two
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      end
      if (pop_en) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end

      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + cnt_t'(1);
        2'b01:   count_q <= count_q - cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* vec_issue_frontend.sv */
// Issue front end of the vector coprocessor
// Issue-ready and take strobe generation
// Decoder, one-entry pre-buffer and instruction FIFO instances

module vec_issue_frontend #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Issue side, from the scalar core
  input  logic                      issue_valid_i,
  input  vec_issue_pkg::issue_req_t issue_req_i,
  output logic                      issue_ready_o,
  output logic                      issue_accept_o,
  // Control
  input  logic                      flush_i,
  input  logic                      flush_unissued_i,
  // Downstream side
  input  logic                      pop_i,
  output logic                      instr_valid_o,
  output vec_issue_pkg::issue_req_t instr_o
);

  logic                      fifo_full;
  logic                      fifo_empty;
  logic                      take;
  logic                      push;
  vec_issue_pkg::issue_req_t push_data;

  //////////////////////////////
  // Issue handshake
  //////////////////////////////

  vec_issue_decoder i_decoder (
    .instr_i  (issue_req_i.instr),
    .accept_o (issue_accept_o   )
  );

  assign issue_ready_o = issue_valid_i && !fifo_full && !flush_i;

  // Rejected words are never stored
  assign take = issue_valid_i && issue_ready_o && issue_accept_o;

  //////////////////////////////
  // Buffering
  //////////////////////////////

  vec_issue_prebuffer i_prebuffer (
    .clk_i            (clk_i           ),
    .rst_ni           (rst_ni          ),
    .load_i           (take            ),
    .load_data_i      (issue_req_i     ),
    .fifo_full_i      (fifo_full       ),
    .flush_unissued_i (flush_unissued_i),
    .push_o           (push            ),
    .push_data_o      (push_data       )
  );

  vec_instr_fifo #(
    .FifoDepth (FifoDepth)
  ) i_instr_fifo (
    .clk_i   (clk_i     ),
    .rst_ni  (rst_ni    ),
    .flush_i (flush_i   ),
    .push_i  (push      ),
    .data_i  (push_data ),
    .pop_i   (pop_i     ),
    .full_o  (fifo_full ),
    .empty_o (fifo_empty),
    .data_o  (instr_o   )
  );

  assign instr_valid_o = !fifo_empty;

endmodule

/* vec_issue_checker.sv */
// Checking module of the issue front end testbench
// Reference queue of taken packets with pre-buffer and FIFO occupancy
// Per-cycle compare of ready, accept, instr_valid_o and the head packet
// Per-test result lines and error counters

module vec_issue_checker #(
  parameter int unsigned FifoDepth = 4
) (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      issue_valid_i,
  input vec_issue_pkg::issue_req_t issue_req_i,
  input logic                      issue_ready_o,
  input logic                      issue_accept_o,
  input logic                      flush_i,
  input logic                      flush_unissued_i,
  input logic                      pop_i,
  input logic                      instr_valid_o,
  input vec_issue_pkg::issue_req_t instr_o,
  input logic                      exp_accept_i
);

  // Packets in take order, the newest may sit in the pre-buffer
  vec_issue_pkg::issue_req_t ref_q[$];
  int unsigned               fifo_cnt;
  logic                      pb_full;

  string cur_name;
  int    test_errs;
  int    err_count;
  int    tests_passed;
  int    tests_failed;

  initial begin
    cur_name     = "none";
    test_errs    = 0;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;
    fifo_cnt     = 0;
    pb_full      = 1'b0;
  end

  task automatic start_test(input string name);
    cur_name  = name;
    test_errs = 0;
  endtask

  task automatic finish_test(input int extra_errs);
    if (test_errs + extra_errs == 0) begin
      tests_passed++;
      $display("PASS %s", cur_name);
    end else begin
      tests_failed++;
      $display("FAIL %s: %0d mismatches", cur_name, test_errs + extra_errs);
    end
  endtask

  task automatic report(input string what, input logic [35:0] exp, input logic [35:0] act);
    test_errs++;
    err_count++;
    $display("[ERROR] %s: %s expected %h, actual %h", cur_name, what, exp, act);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  always @(posedge clk_i) begin
    logic exp_ready;
    logic take;
    logic push;
    logic pop;

    if (!rst_ni) begin
      ref_q.delete();
      fifo_cnt = 0;
      pb_full  = 1'b0;
    end else begin
      exp_ready = issue_valid_i && (fifo_cnt < FifoDepth) && !flush_i;
      take      = exp_ready && exp_accept_i;
      push      = pb_full && (fifo_cnt < FifoDepth) && !flush_unissued_i;
      pop       = pop_i && (fifo_cnt > 0) && !flush_i;

      if (issue_ready_o !== exp_ready) begin
        report("issue_ready_o", 36'(exp_ready), 36'(issue_ready_o));
      end
      if (issue_valid_i && (issue_accept_o !== exp_accept_i)) begin
        report("issue_accept_o", 36'(exp_accept_i), 36'(issue_accept_o));
      end
      if (instr_valid_o !== (fifo_cnt > 0)) begin
        report("instr_valid_o", 36'(fifo_cnt > 0), 36'(instr_valid_o));
      end else if (instr_valid_o && (instr_o !== ref_q[0])) begin
        report("instr_o", ref_q[0], instr_o);
      end

      if (flush_i) begin
        // Everything is dropped together
        ref_q.delete();
        fifo_cnt = 0;
        pb_full  = 1'b0;
      end else begin
        if (pop) begin
          void'(ref_q.pop_front());
          fifo_cnt--;
        end
        if (push) begin
          fifo_cnt++;
        end
        if (flush_unissued_i) begin
          if (pb_full) begin
            void'(ref_q.pop_back());
          end
          pb_full = 1'b0;
        end else if (take) begin
          ref_q.push_back(issue_req_i);
          pb_full = 1'b1;
        end else if (push) begin
          pb_full = 1'b0;
        end
      end
    end
  end

endmodule

/* vec_issue_assert.sv */
// Concurrent assertions on the issue front end top level
// Bound into every vec_issue_frontend instance

module vec_issue_assert (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      flush_i,
  input logic                      pop_i,
  input logic                      instr_valid_o,
  input vec_issue_pkg::issue_req_t instr_o
);

  // FIFO runs empty one edge after a flush
  flush_empties_fifo: assert property (
    @(posedge clk_i) disable iff (!rst_ni) flush_i |=> !instr_valid_o
  ) else $error("instr_valid_o still high after flush_i");

  idle_after_reset: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> !instr_valid_o
  ) else $error("instr_valid_o high right after reset");

  // Head holds until popped or flushed
  head_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (instr_valid_o && !pop_i && !flush_i) |=> $stable(instr_o)
  ) else $error("instr_o changed without pop or flush");

endmodule

bind vec_issue_frontend vec_issue_assert assert_inst (
  .clk_i         (clk_i        ),
  .rst_ni        (rst_ni       ),
  .flush_i       (flush_i      ),
  .pop_i         (pop_i        ),
  .instr_valid_o (instr_valid_o),
  .instr_o       (instr_o      )
);

/* vec_issue_frontend_tb.sv */
// Testbench of the vector issue front end
// Clock, reset, xorshift generator, stimulus table and its loop
// Drain between tests, cycle timeout and the closing counts

module vec_issue_frontend_tb;

  localparam int unsigned FifoDepth = 4;

  typedef struct packed {
    logic                     valid;
    vec_issue_pkg::instr_t    instr;
    vec_issue_pkg::hartid_t   hartid;
    vec_issue_pkg::trans_id_t id;
    logic                     flush;
    logic                     flush_unissued;
    logic                     pop;
    logic                     exp_accept;
  } row_t;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      issue_valid_i;
  vec_issue_pkg::issue_req_t issue_req_i;
  logic                      issue_ready_o;
  logic                      issue_accept_o;
  logic                      flush_i;
  logic                      flush_unissued_i;
  logic                      pop_i;
  logic                      instr_valid_o;
  vec_issue_pkg::issue_req_t instr_o;
  logic                      exp_accept;

  string       row_name[$];
  row_t        rows[$];
  logic [31:0] rng;
  int unsigned cycle_cnt;
  int unsigned timeout_limit;
  int          drain_errs;
  int          total_errs;

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  vec_issue_frontend #(
    .FifoDepth (FifoDepth)
  ) vec_issue_frontend_inst (
    .clk_i            (clk_i           ),
    .rst_ni           (rst_ni          ),
    .issue_valid_i    (issue_valid_i   ),
    .issue_req_i      (issue_req_i     ),
    .issue_ready_o    (issue_ready_o   ),
    .issue_accept_o   (issue_accept_o  ),
    .flush_i          (flush_i         ),
    .flush_unissued_i (flush_unissued_i),
    .pop_i            (pop_i           ),
    .instr_valid_o    (instr_valid_o   ),
    .instr_o          (instr_o         )
  );

  vec_issue_checker #(
    .FifoDepth (FifoDepth)
  ) checker_inst (
    .clk_i            (clk_i           ),
    .rst_ni           (rst_ni          ),
    .issue_valid_i    (issue_valid_i   ),
    .issue_req_i      (issue_req_i     ),
    .issue_ready_o    (issue_ready_o   ),
    .issue_accept_o   (issue_accept_o  ),
    .flush_i          (flush_i         ),
    .flush_unissued_i (flush_unissued_i),
    .pop_i            (pop_i           ),
    .instr_valid_o    (instr_valid_o   ),
    .instr_o          (instr_o         ),
    .exp_accept_i     (exp_accept      )
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Random filler around a given opcode and width field
  function automatic vec_issue_pkg::instr_t make_word(input logic [6:0] opcode,
                                                       input logic [2:0] width);
    rng = xorshift(rng);
    return {rng[31:15], width, rng[11:7], opcode};
  endfunction

  task automatic add_row(input string name, input logic valid, input vec_issue_pkg::instr_t instr,
                         input logic flush, input logic flush_unissued, input logic pop,
                         input logic accept);
    row_t r;
    rng             = xorshift(rng);
    r.valid          = valid;
    r.instr          = instr;
    r.hartid         = rng[0];
    r.id             = rng[3:1];
    r.flush          = flush;
    r.flush_unissued = flush_unissued;
    r.pop            = pop;
    r.exp_accept     = accept;
    row_name.push_back(name);
    rows.push_back(r);
  endtask

  task automatic idle_row(input string name, input logic pop);
    add_row(name, 1'b0, '0, 1'b0, 1'b0, pop, 1'b0);
  endtask

  task automatic vec_row(input string name, input logic pop);
    add_row(name, 1'b1, make_word(7'h57, 3'd0), 1'b0, 1'b0, pop, 1'b1);
  endtask

  // Pop until the FIFO and pre-buffer have both run dry
  task automatic drain(output int errs);
    int quiet;
    errs  = 0;
    quiet = 0;
    for (int i = 0; i < FifoDepth + 4 && quiet < 2; i++) begin
      @(negedge clk_i);
      issue_valid_i    = 1'b0;
      flush_i          = 1'b0;
      flush_unissued_i = 1'b0;
      pop_i            = instr_valid_o;
      quiet            = instr_valid_o ? 0 : quiet + 1;
      @(posedge clk_i);
    end
    @(negedge clk_i);
    pop_i = 1'b0;
    if (quiet < 2) begin
      errs = 1;
      $display("Drain did not empty the FIFO within %0d cycles", FifoDepth + 4);
    end
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  task automatic build_table();
    idle_row("reset_idle", 1'b0);
    idle_row("reset_idle", 1'b0);

    // Accepted forms popped as they come out
    vec_row("decode", 1'b1);
    add_row("decode", 1'b1, make_word(7'h07, 3'd0), 1'b0, 1'b0, 1'b1, 1'b1);
    add_row("decode", 1'b1, make_word(7'h07, 3'd5), 1'b0, 1'b0, 1'b1, 1'b1);
    add_row("decode", 1'b1, make_word(7'h27, 3'd6), 1'b0, 1'b0, 1'b1, 1'b1);
    add_row("decode", 1'b1, make_word(7'h27, 3'd7), 1'b0, 1'b0, 1'b1, 1'b1);
    // Scalar FP widths and foreign opcodes
    add_row("decode", 1'b1, make_word(7'h07, 3'd1), 1'b0, 1'b0, 1'b1, 1'b0);
    add_row("decode", 1'b1, make_word(7'h07, 3'd2), 1'b0, 1'b0, 1'b1, 1'b0);
    add_row("decode", 1'b1, make_word(7'h27, 3'd3), 1'b0, 1'b0, 1'b1, 1'b0);
    add_row("decode", 1'b1, make_word(7'h33, 3'd0), 1'b0, 1'b0, 1'b1, 1'b0);
    add_row("decode", 1'b1, make_word(7'h13, 3'd6), 1'b0, 1'b0, 1'b1, 1'b0);

    vec_row("single_latency", 1'b0);
    for (int i = 0; i < 3; i++) idle_row("single_latency", 1'b0);

    for (int i = 0; i < 4; i++) vec_row("order", 1'b1);

    // Two extra rows find issue_ready_o low
    for (int i = 0; i < 7; i++) vec_row("backpressure", 1'b0);
    // One pop frees a slot and ready returns for the next word
    idle_row("backpressure", 1'b1);
    add_row("backpressure", 1'b1, make_word(7'h33, 3'd0), 1'b0, 1'b0, 1'b0, 1'b0);

    for (int i = 0; i < 3; i++) vec_row("flush_all", 1'b0);
    add_row("flush_all", 1'b0, '0, 1'b1, 1'b1, 1'b0, 1'b0);
    idle_row("flush_all", 1'b0);

    for (int i = 0; i < 3; i++) vec_row("flush_unissued", 1'b0);
    add_row("flush_unissued", 1'b0, '0, 1'b0, 1'b1, 1'b0, 1'b0);
    idle_row("flush_unissued", 1'b0);
  endtask

  //////////////////////////////
  // Timeout
  //////////////////////////////

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (timeout_limit != 0 && cycle_cnt > timeout_limit) begin
      $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
      $display("test failed");
      $finish;
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int n_tests;
    int errs;

    rst_ni           = 1'b0;
    issue_valid_i    = 1'b0;
    issue_req_i      = '0;
    flush_i          = 1'b0;
    flush_unissued_i = 1'b0;
    pop_i            = 1'b0;
    exp_accept       = 1'b0;
    cycle_cnt        = 0;
    timeout_limit    = 0;
    drain_errs       = 0;
    rng              = 32'h8a61_a8f1;

    build_table();
    n_tests = 7;
    // Row cycles, drain budget per test, reset and margin
    timeout_limit = rows.size() + n_tests * (FifoDepth + 6) + 10 + 50;

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    checker_inst.start_test(row_name[0]);
    for (int i = 0; i < rows.size(); i++) begin
      if (i > 0 && row_name[i] != row_name[i-1]) begin
        drain(errs);
        drain_errs += errs;
        checker_inst.finish_test(errs);
        checker_inst.start_test(row_name[i]);
      end
      @(negedge clk_i);
      issue_valid_i       = rows[i].valid;
      issue_req_i.instr   = rows[i].instr;
      issue_req_i.hartid  = rows[i].hartid;
      issue_req_i.id      = rows[i].id;
      flush_i             = rows[i].flush;
      flush_unissued_i    = rows[i].flush_unissued;
      pop_i               = rows[i].pop;
      exp_accept          = rows[i].exp_accept;
      @(posedge clk_i);
    end
    drain(errs);
    drain_errs += errs;
    checker_inst.finish_test(errs);

    total_errs = checker_inst.err_count + drain_errs;
    $display("Tests: %0d passed, %0d failed, %0d errors", checker_inst.tests_passed,
             checker_inst.tests_failed, total_errs);
    if (total_errs == 0 && checker_inst.tests_failed == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* vec_issue_frontend.f */
vec_issue_pkg.sv
vec_issue_decoder.sv
vec_issue_prebuffer.sv
vec_instr_fifo.sv
vec_issue_frontend.sv
vec_issue_checker.sv
vec_issue_assert.sv
vec_issue_frontend_tb.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module vec_issue_frontend_tb -f vec_issue_frontend.f

sim:
	verilator --binary --timing --assert --top-module vec_issue_frontend_tb \
		-f vec_issue_frontend.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
